// ==== all.f ====
hyper_pkg.sv
hyper_fifo.sv
hyper_cycle_counter.sv
hyper_ca_shifter.sv
hyper_word_serdes.sv
hyper_ctrl_fsm.sv
hyperbus_top.sv
hyperram_model.sv
hyperbus_assert.sv
hyperbus_tb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = hyperbus_tb
FLIST = all.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)

run: compile
	./$(BUILD)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hyperbus_tb.sv ====
`default_nettype none

module hyperbus_tb;

  localparam int ADDR_WIDTH = 22;
  localparam int LATENCY    = 12;
  localparam int MAX_BURST  = 16;
  localparam int REQ_DEPTH  = 4;
  localparam int LEN_W      = $clog2(MAX_BURST);
  localparam int LIMIT      = 2000;

  typedef logic [ADDR_WIDTH-1:0]            addr_t;
  typedef logic [hyper_pkg::WORD_WIDTH-1:0] word_t;

  logic                         clk_i;
  logic                         reset_i;
  logic                         req_valid_i;
  logic                         req_ready_o;
  logic                         req_write_i;
  logic                         req_reg_i;
  addr_t                        req_addr_i;
  logic [LEN_W-1:0]             req_len_i;
  logic                         wdata_valid_i;
  logic                         wdata_ready_o;
  word_t                        wdata_i;
  logic                         rdata_valid_o;
  logic                         rdata_ready_i;
  word_t                        rdata_o;
  logic                         wdone_valid_o;
  logic                         wdone_ready_i;
  logic                         cs_no;
  logic                         ck_o;
  logic                         ck_no;
  logic [hyper_pkg::DQ_WIDTH-1:0] dq_o;
  logic                         dq_oe_o;
  logic                         rwds;
  logic                         reset_no;
  wire [hyper_pkg::DQ_WIDTH-1:0] dq;

  // reference memory and register copy
  word_t ref_mem [addr_t];
  word_t ref_cfg;

  int    errors;
  int    checks;
  int    wdone_seen;
  int    writes_sent;
  logic  hung;

  // controller side of the shared dq pins
  assign dq = dq_oe_o ? dq_o : 'z;

  hyperbus_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .LATENCY    (LATENCY),
    .MAX_BURST  (MAX_BURST),
    .REQ_DEPTH  (REQ_DEPTH)
  ) u_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_write_i   (req_write_i),
    .req_reg_i     (req_reg_i),
    .req_addr_i    (req_addr_i),
    .req_len_i     (req_len_i),
    .wdata_valid_i (wdata_valid_i),
    .wdata_ready_o (wdata_ready_o),
    .wdata_i       (wdata_i),
    .rdata_valid_o (rdata_valid_o),
    .rdata_ready_i (rdata_ready_i),
    .rdata_o       (rdata_o),
    .wdone_valid_o (wdone_valid_o),
    .wdone_ready_i (wdone_ready_i),
    .cs_no         (cs_no),
    .ck_o          (ck_o),
    .ck_no         (ck_no),
    .dq_o          (dq_o),
    .dq_i          (dq),
    .dq_oe_o       (dq_oe_o),
    .rwds_i        (rwds),
    .reset_no      (reset_no)
  );

  hyperram_model #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .LATENCY    (LATENCY)
  ) u_ram (
    .cs_ni    (cs_no),
    .ck_i     (ck_o),
    .reset_ni (reset_no),
    .dq_io    (dq),
    .rwds_o   (rwds)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #10 clk_i = ~clk_i;

  // completions counted mid-cycle, transfer at the next rising edge
  always @(negedge clk_i) begin
    if (wdone_valid_o && wdone_ready_i) begin
      wdone_seen <= wdone_seen + 1;
    end
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_done(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0t: %0d write completions, expected %0d", $time, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    hung = 1'b1;
    $display("timeout: no %s within %0d cycles at %0t", what, LIMIT, $time);
  endtask

  task automatic send_req(input logic wr, input logic rg, input addr_t a, input int len);
    int t;
    if (hung) return;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_write_i <= wr;
    req_reg_i   <= rg;
    req_addr_i  <= a;
    req_len_i   <= LEN_W'(len);
    t = 0;
    @(negedge clk_i);
    while (!req_ready_o && t < LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (!req_ready_o) begin
      note_timeout("request accept");
      return;
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // random idle cycles between words when max_gap is nonzero
  task automatic send_words(input word_t words[$], input int max_gap);
    int t;
    int gap;
    if (hung) return;
    @(posedge clk_i);
    foreach (words[i]) begin
      gap = (max_gap > 0) ? int'($urandom_range(0, max_gap)) : 0;
      if (gap > 0) begin
        wdata_valid_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
      wdata_valid_i <= 1'b1;
      wdata_i       <= words[i];
      t = 0;
      @(negedge clk_i);
      while (!wdata_ready_o && t < LIMIT) begin
        @(negedge clk_i);
        t++;
      end
      if (!wdata_ready_o) begin
        note_timeout("write data accept");
        return;
      end
      @(posedge clk_i);
    end
    wdata_valid_i <= 1'b0;
  endtask

  // completion held off for a few random cycles
  // ready then stays high so any extra completion is counted too
  task automatic take_wdone(input int target);
    int t;
    int hold_off;
    if (hung) return;
    hold_off = int'($urandom_range(0, 3));
    @(posedge clk_i);
    wdone_ready_i <= 1'b0;
    repeat (hold_off) @(posedge clk_i);
    wdone_ready_i <= 1'b1;
    t = 0;
    while (wdone_seen < target && t < LIMIT) begin
      @(posedge clk_i);
      t++;
    end
    if (wdone_seen < target) begin
      note_timeout("write completion");
    end
  endtask

  // stall drops rdata_ready_i at random
  task automatic recv_words(input word_t exp[$], input logic stall, input string what);
    int t;
    int got;
    if (hung) return;
    t = 0;
    got = 0;
    while (got < exp.size() && t < LIMIT) begin
      @(posedge clk_i);
      rdata_ready_i <= stall ? ($urandom_range(0, 2) != 0) : 1'b1;
      @(negedge clk_i);
      if (rdata_valid_o && rdata_ready_i) begin
        check_word(rdata_o, exp[got], what);
        got++;
      end
      t++;
    end
    @(posedge clk_i);
    rdata_ready_i <= 1'b0;
    if (got < exp.size()) begin
      note_timeout("read data word");
    end
  endtask

  task automatic write_burst(input logic rg, input addr_t a, input word_t words[$],
                             input int max_gap);
    send_req(1'b1, rg, a, words.size() - 1);
    send_words(words, max_gap);
    take_wdone(writes_sent + 1);
    writes_sent++;
    foreach (words[i]) begin
      if (rg) begin
        ref_cfg = words[i];
      end else begin
        ref_mem[addr_t'(a + addr_t'(i))] = words[i];
      end
    end
    check_done(wdone_seen, writes_sent);
  endtask

  task automatic read_burst(input logic rg, input addr_t a, input int len, input logic stall);
    word_t exp[$];
    for (int i = 0; i <= len; i++) begin
      exp.push_back(rg ? ref_cfg : ref_mem[addr_t'(a + addr_t'(i))]);
    end
    send_req(1'b0, rg, a, len);
    recv_words(exp, stall, rg ? "register" : "memory");
  endtask

  function automatic word_t rand_word();
    return word_t'($urandom);
  endfunction

  initial begin
    addr_t addrs[$];
    addr_t a;
    int    lens[$];
    int    len;
    word_t words[$];
    void'($urandom(32'hfd61_fd8e));
    reset_i       = 1'b1;
    req_valid_i   = 1'b0;
    req_write_i   = 1'b0;
    req_reg_i     = 1'b0;
    req_addr_i    = '0;
    req_len_i     = '0;
    wdata_valid_i = 1'b0;
    wdata_i       = '0;
    rdata_ready_i = 1'b0;
    wdone_ready_i = 1'b0;
    errors        = 0;
    checks        = 0;
    wdone_seen    = 0;
    writes_sent   = 0;
    hung          = 1'b0;
    ref_cfg       = hyper_pkg::CFG_REG_RESET;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (3) @(posedge clk_i);

    // register space, reset value then zero-latency write
    read_burst(1'b1, '0, 0, 1'b0);
    words = {rand_word()};
    write_burst(1'b1, '0, words, 0);
    read_burst(1'b1, '0, 0, 1'b0);

    // single words, all writes first
    for (int i = 0; i < 8; i++) begin
      a = addr_t'($urandom);
      addrs.push_back(a);
      words = {rand_word()};
      write_burst(1'b0, a, words, 0);
    end
    foreach (addrs[i]) begin
      read_burst(1'b0, addrs[i], 0, 1'b0);
    end

    // bursts of random length
    addrs.delete();
    for (int i = 0; i < 6; i++) begin
      a   = addr_t'($urandom);
      len = int'($urandom_range(0, MAX_BURST - 1));
      words.delete();
      for (int j = 0; j <= len; j++) begin
        words.push_back(rand_word());
      end
      write_burst(1'b0, a, words, 0);
      read_burst(1'b0, a, len, 1'b0);
      addrs.push_back(a);
      lens.push_back(len);
    end

    // full burst with write data gaps
    a = addr_t'($urandom);
    words.delete();
    for (int j = 0; j < MAX_BURST; j++) begin
      words.push_back(rand_word());
    end
    write_burst(1'b0, a, words, 4);
    read_burst(1'b0, a, MAX_BURST - 1, 1'b0);

    // back-pressure on read data
    read_burst(1'b0, a, MAX_BURST - 1, 1'b1);
    foreach (addrs[i]) begin
      read_burst(1'b0, addrs[i], lens[i], 1'b1);
    end

    repeat (5) @(posedge clk_i);
    check_done(wdone_seen, writes_sent);
    $display("checks %0d, errors %0d, write completions %0d", checks, errors, wdone_seen);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hyperbus_assert.sv ====
`default_nettype none

module hyperbus_assert (
  input logic clk_i,
  input logic reset_i,
  input logic cs_ni,
  input logic ck_i,
  input logic ck_ni,
  input logic dq_oe_i
);

  // chip select released when reset ends
  cs_high_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> cs_ni)
    else $error("cs_no low as reset ends");

  // no pin drive without a selected device
  no_drive_while_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    cs_ni |-> !dq_oe_i)
    else $error("dq driven while cs_no high");

  // bus clock parked between transactions
  ck_still_while_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    cs_ni |-> $stable(ck_i))
    else $error("ck_o toggled while cs_no high");

  // differential clock pair stays complementary
  ck_pair_complement: assert property (@(posedge clk_i) disable iff (reset_i)
    ck_ni == !ck_i)
    else $error("ck_no not the complement of ck_o");

endmodule

bind hyperbus_top hyperbus_assert u_assert (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .cs_ni   (cs_no),
  .ck_i    (ck_o),
  .ck_ni   (ck_no),
  .dq_oe_i (dq_oe_o)
);

`default_nettype wire

// ==== hyperram_model.sv ====
`default_nettype none

module hyperram_model #(
  parameter int ADDR_WIDTH = 22,
  parameter int LATENCY    = 12
) (
  input  logic                           cs_ni,
  input  logic                           ck_i,
  input  logic                           reset_ni,
  inout  wire [hyper_pkg::DQ_WIDTH-1:0]  dq_io,
  output logic                           rwds_o
);

  typedef logic [ADDR_WIDTH-1:0]            addr_t;
  typedef logic [hyper_pkg::WORD_WIDTH-1:0] word_t;

  word_t                          mem [addr_t];
  word_t                          cfg_q;
  logic [hyper_pkg::CA_WIDTH-1:0] ca_q;
  logic [hyper_pkg::DQ_WIDTH-1:0] rbyte_q;
  logic [hyper_pkg::DQ_WIDTH-1:0] whi_q;
  logic                           drive_q;
  logic                           rd_q;
  logic                           rg_q;
  addr_t                          addr_q;
  int                             edge_q;
  int                             data_start;

  // memory answers only in read data
  assign dq_io = drive_q ? rbyte_q : 'z;

  // unwritten words depend on every address bit
  function automatic word_t fill(input addr_t a);
    return 16'(a) ^ 16'(a >> 8) ^ 16'h3c5a;
  endfunction

  function automatic word_t read_word(input addr_t a);
    if (rg_q) begin
      return cfg_q;
    end
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill(a);
  endfunction

  // every ck edge moves one byte while selected
  always @(posedge ck_i or negedge ck_i or posedge cs_ni or negedge reset_ni) begin
    word_t w;
    if (!reset_ni) begin
      cfg_q   = hyper_pkg::CFG_REG_RESET;
      edge_q  = 0;
      drive_q = 1'b0;
      rwds_o  = 1'b0;
    end else if (cs_ni) begin
      // deselect ends the transaction
      edge_q  = 0;
      drive_q = 1'b0;
      rwds_o  = 1'b0;
    end else begin
      if (edge_q < hyper_pkg::CA_BYTES) begin
        ca_q = {ca_q[hyper_pkg::CA_WIDTH-hyper_pkg::DQ_WIDTH-1:0], dq_io};
        if (edge_q == hyper_pkg::CA_BYTES - 1) begin
          rd_q = ca_q[hyper_pkg::CA_RW_BIT];
          rg_q = ca_q[hyper_pkg::CA_AS_BIT];
          addr_q = {ca_q[hyper_pkg::CA_ROW_LSB +: ADDR_WIDTH - hyper_pkg::CA_COL_BITS],
                    ca_q[hyper_pkg::CA_COL_BITS-1:0]};
          // register writes start data right after CA
          data_start = (!rd_q && rg_q) ? hyper_pkg::CA_BYTES
                                       : hyper_pkg::CA_BYTES + LATENCY;
        end
      end else if (edge_q >= data_start) begin
        if (rd_q) begin
          w = read_word(addr_q);
          if (((edge_q - data_start) % 2) == 0) begin
            rbyte_q = w[15:8];
          end else begin
            rbyte_q = w[7:0];
            addr_q  = addr_q + 1'b1;
          end
          drive_q = 1'b1;
          rwds_o  = 1'b1;
        end else if (((edge_q - data_start) % 2) == 0) begin
          whi_q = dq_io;
        end else begin
          if (rg_q) begin
            cfg_q = {whi_q, dq_io};
          end else begin
            mem[addr_q] = {whi_q, dq_io};
          end
          addr_q = addr_q + 1'b1;
        end
      end
      edge_q = edge_q + 1;
    end
  end

endmodule

`default_nettype wire

// ==== hyperbus_top.sv ====
`default_nettype none

module hyperbus_top #(
  parameter int ADDR_WIDTH = 22,
  parameter int LATENCY    = 12,
  parameter int MAX_BURST  = 16,
  parameter int REQ_DEPTH  = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // request channel
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic                             req_write_i,
  input  logic                             req_reg_i,
  input  logic [ADDR_WIDTH-1:0]            req_addr_i,
  input  logic [$clog2(MAX_BURST)-1:0]     req_len_i,
  // write data channel
  input  logic                             wdata_valid_i,
  output logic                             wdata_ready_o,
  input  logic [hyper_pkg::WORD_WIDTH-1:0] wdata_i,
  // read data channel
  output logic                             rdata_valid_o,
  input  logic                             rdata_ready_i,
  output logic [hyper_pkg::WORD_WIDTH-1:0] rdata_o,
  // write completion
  output logic                             wdone_valid_o,
  input  logic                             wdone_ready_i,
  // HyperBus pins
  output logic                             cs_no,
  output logic                             ck_o,
  output logic                             ck_no,
  output logic [hyper_pkg::DQ_WIDTH-1:0]   dq_o,
  input  logic [hyper_pkg::DQ_WIDTH-1:0]   dq_i,
  output logic                             dq_oe_o,
  input  logic                             rwds_i,
  output logic                             reset_no
);

  // one queued request
  typedef struct packed {
    logic                         write;
    logic                         reg_space;
    logic [ADDR_WIDTH-1:0]        addr;
    logic [$clog2(MAX_BURST)-1:0] len;
  } req_t;

  typedef logic [hyper_pkg::WORD_WIDTH-1:0] word_t;

  req_t                           req_in;
  req_t                           req_q;
  logic                           req_full;
  logic                           req_empty;
  logic                           req_pop;
  logic [$clog2(MAX_BURST+1)-1:0] rfifo_free;
  logic                           rfifo_empty;
  word_t                          rword;
  logic                           rword_valid;
  logic                           cnt_load;
  logic [7:0]                     cnt_value;
  logic                           cnt_enable;
  logic                           cnt_done;
  logic                           cnt_odd;
  logic                           ca_load;
  logic                           ca_shift;
  logic [hyper_pkg::DQ_WIDTH-1:0] ca_byte;
  logic [hyper_pkg::DQ_WIDTH-1:0] wbyte;
  logic                           wload;
  logic                           rcapture;
  logic                           dq_sel_ca;
  logic                           reset_nq;

  assign req_in = '{write: req_write_i, reg_space: req_reg_i, addr: req_addr_i, len: req_len_i};
  assign req_ready_o = !req_full;

  hyper_fifo #(
    .DEPTH     (REQ_DEPTH),
    .payload_t (req_t)
  ) u_req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (req_valid_i),
    .data_i  (req_in),
    .full_o  (req_full),
    .pop_i   (req_pop),
    .data_o  (req_q),
    .empty_o (req_empty),
    .free_o  ()
  );

  // room is reserved before a read starts
  // so its full flag is never needed
  hyper_fifo #(
    .DEPTH     (MAX_BURST),
    .payload_t (word_t)
  ) u_rdata_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (rword_valid),
    .data_i  (rword),
    .full_o  (),
    .pop_i   (rdata_valid_o && rdata_ready_i),
    .data_o  (rdata_o),
    .empty_o (rfifo_empty),
    .free_o  (rfifo_free)
  );

  assign rdata_valid_o = !rfifo_empty;

  hyper_ctrl_fsm #(
    .LATENCY   (LATENCY),
    .MAX_BURST (MAX_BURST)
  ) u_fsm (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_empty_i   (req_empty),
    .req_write_i   (req_q.write),
    .req_reg_i     (req_q.reg_space),
    .req_len_i     (req_q.len),
    .req_pop_o     (req_pop),
    .rfifo_free_i  (rfifo_free),
    .wdata_valid_i (wdata_valid_i),
    .wdata_ready_o (wdata_ready_o),
    .rwds_i        (rwds_i),
    .cnt_load_o    (cnt_load),
    .cnt_value_o   (cnt_value),
    .cnt_enable_o  (cnt_enable),
    .cnt_done_i    (cnt_done),
    .cnt_odd_i     (cnt_odd),
    .ca_load_o     (ca_load),
    .ca_shift_o    (ca_shift),
    .wload_o       (wload),
    .rcapture_o    (rcapture),
    .dq_sel_ca_o   (dq_sel_ca),
    .cs_no         (cs_no),
    .ck_o          (ck_o),
    .ck_no         (ck_no),
    .dq_oe_o       (dq_oe_o),
    .wdone_valid_o (wdone_valid_o),
    .wdone_ready_i (wdone_ready_i)
  );

  hyper_cycle_counter u_counter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .load_i       (cnt_load),
    .load_value_i (cnt_value),
    .enable_i     (cnt_enable),
    .done_o       (cnt_done),
    .odd_o        (cnt_odd)
  );

  hyper_ca_shifter #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ca (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (ca_load),
    .write_i (req_q.write),
    .reg_i   (req_q.reg_space),
    .addr_i  (req_q.addr),
    .shift_i (ca_shift),
    .byte_o  (ca_byte)
  );

  // counter parity picks the byte half for both directions
  hyper_word_serdes u_serdes (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wword_i       (wdata_i),
    .wload_i       (wload),
    .wbyte_o       (wbyte),
    .byte_sel_i    (cnt_odd),
    .rbyte_i       (dq_i),
    .rcapture_i    (rcapture),
    .rword_o       (rword),
    .rword_valid_o (rword_valid)
  );

  // CA bytes first, write bytes after
  assign dq_o = dq_sel_ca ? ca_byte : wbyte;

  // device reset follows reset_i one cycle late on release
  always_ff @(posedge clk_i) begin
    reset_nq <= !reset_i;
  end

  assign reset_no = reset_nq;

endmodule

`default_nettype wire

// ==== hyper_ctrl_fsm.sv ====
`default_nettype none

module hyper_ctrl_fsm #(
  parameter int LATENCY   = 12,
  parameter int MAX_BURST = 16
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           req_empty_i,
  input  logic                           req_write_i,
  input  logic                           req_reg_i,
  input  logic [$clog2(MAX_BURST)-1:0]   req_len_i,
  output logic                           req_pop_o,
  input  logic [$clog2(MAX_BURST+1)-1:0] rfifo_free_i,
  input  logic                           wdata_valid_i,
  output logic                           wdata_ready_o,
  input  logic                           rwds_i,
  output logic                           cnt_load_o,
  output logic [7:0]                     cnt_value_o,
  output logic                           cnt_enable_o,
  input  logic                           cnt_done_i,
  input  logic                           cnt_odd_i,
  output logic                           ca_load_o,
  output logic                           ca_shift_o,
  output logic                           wload_o,
  output logic                           rcapture_o,
  output logic                           dq_sel_ca_o,
  output logic                           cs_no,
  output logic                           ck_o,
  output logic                           ck_no,
  output logic                           dq_oe_o,
  output logic                           wdone_valid_o,
  input  logic                           wdone_ready_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CMD,
    S_LAT,
    S_WDATA,
    S_RDATA,
    S_FINISH,
    S_DWAIT
  } state_t;

  state_t                         state_q;
  state_t                         state_d;
  logic                           write_q;
  logic                           reg_q;
  logic [$clog2(MAX_BURST)-1:0]   len_q;
  logic                           wfull_q;
  logic                           start;
  logic                           wmove;
  logic                           ck_move;
  logic                           ck_q;
  logic                           cs_nq;
  logic [7:0]                     data_count;

  // reads wait until a whole burst fits in the read FIFO
  assign start = (state_q == S_IDLE) && !req_empty_i &&
                 (req_write_i || (rfifo_free_i >= MAX_BURST));

  // two bytes per word
  assign data_count = 8'({len_q, 1'b0}) + 8'd2;

  // write bytes move only while a word is held
  assign wmove      = (state_q == S_WDATA) && wfull_q;
  assign rcapture_o = (state_q == S_RDATA) && rwds_i;

  assign cnt_enable_o = (state_q == S_CMD) || (state_q == S_LAT) || wmove || rcapture_o;

  // ck runs through CA and latency
  // in read data it runs so the memory can answer
  assign ck_move = (state_q == S_CMD) || (state_q == S_LAT) || wmove ||
                   (state_q == S_RDATA);

  assign req_pop_o   = start;
  assign ca_load_o   = start;
  assign ca_shift_o  = (state_q == S_CMD);
  assign dq_sel_ca_o = (state_q == S_CMD);
  assign dq_oe_o     = (state_q == S_CMD) || (state_q == S_WDATA);

  // prefetch the first word during CA and latency
  // then take the next one as the low byte leaves, unless it is the last byte
  assign wdata_ready_o = write_q &&
    ((((state_q == S_CMD) || (state_q == S_LAT) || (state_q == S_WDATA)) && !wfull_q) ||
     (wmove && cnt_odd_i && !cnt_done_i));
  assign wload_o = wdata_valid_i && wdata_ready_o;

  assign wdone_valid_o = (state_q == S_DWAIT);

  always_comb begin
    state_d     = state_q;
    cnt_load_o  = 1'b0;
    cnt_value_o = data_count;
    case (state_q)
      S_IDLE: begin
        if (start) begin
          state_d     = S_CMD;
          cnt_load_o  = 1'b1;
          cnt_value_o = 8'(hyper_pkg::CA_BYTES);
        end
      end
      S_CMD: begin
        if (cnt_done_i) begin
          cnt_load_o = 1'b1;
          // register writes carry no latency
          if (write_q && reg_q) begin
            state_d = S_WDATA;
          end else begin
            state_d     = S_LAT;
            cnt_value_o = 8'(LATENCY);
          end
        end
      end
      S_LAT: begin
        if (cnt_done_i) begin
          cnt_load_o = 1'b1;
          state_d    = write_q ? S_WDATA : S_RDATA;
        end
      end
      S_WDATA, S_RDATA: begin
        if (cnt_done_i) begin
          state_d = S_FINISH;
        end
      end
      S_FINISH: state_d = write_q ? S_DWAIT : S_IDLE;
      // completion held until the client takes it
      S_DWAIT: begin
        if (wdone_ready_i) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
      wfull_q <= 1'b0;
      cs_nq   <= 1'b1;
    end else begin
      state_q <= state_d;
      // chip select low for every phase that uses the bus
      cs_nq   <= !(state_d inside {S_CMD, S_LAT, S_WDATA, S_RDATA});
      if (wload_o) begin
        wfull_q <= 1'b1;
      end else if (wmove && cnt_odd_i) begin
        wfull_q <= 1'b0;
      end
    end
  end

  // request fields kept for the whole transaction
  always_ff @(posedge clk_i) begin
    if (start) begin
      write_q <= req_write_i;
      reg_q   <= req_reg_i;
      len_q   <= req_len_i;
    end
  end

  // ck edges fall mid-cycle while dq is steady
  always_ff @(negedge clk_i) begin
    if (reset_i) begin
      ck_q <= 1'b0;
    end else if (ck_move) begin
      ck_q <= ~ck_q;
    end
  end

  assign ck_o  = ck_q;
  assign ck_no = ~ck_q;
  assign cs_no = cs_nq;

endmodule

`default_nettype wire

// ==== hyper_word_serdes.sv ====
`default_nettype none

module hyper_word_serdes (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [hyper_pkg::WORD_WIDTH-1:0] wword_i,
  input  logic                             wload_i,
  output logic [hyper_pkg::DQ_WIDTH-1:0]   wbyte_o,
  input  logic                             byte_sel_i,
  input  logic [hyper_pkg::DQ_WIDTH-1:0]   rbyte_i,
  input  logic                             rcapture_i,
  output logic [hyper_pkg::WORD_WIDTH-1:0] rword_o,
  output logic                             rword_valid_o
);

  logic [hyper_pkg::WORD_WIDTH-1:0] wword_q;
  logic [hyper_pkg::DQ_WIDTH-1:0]   rhi_q;
  logic [hyper_pkg::DQ_WIDTH-1:0]   rlo_q;
  logic                             rvalid_q;

  // write word being serialized
  always_ff @(posedge clk_i) begin
    if (wload_i) begin
      wword_q <= wword_i;
    end
  end

  // byte_sel low picks the high byte, sent first
  assign wbyte_o = byte_sel_i ? wword_q[hyper_pkg::DQ_WIDTH-1:0]
                              : wword_q[hyper_pkg::WORD_WIDTH-1:hyper_pkg::DQ_WIDTH];

  // read bytes land in the half that byte_sel names
  always_ff @(posedge clk_i) begin
    if (rcapture_i) begin
      if (byte_sel_i) begin
        rlo_q <= rbyte_i;
      end else begin
        rhi_q <= rbyte_i;
      end
    end
  end

  // word complete after the low byte
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rcapture_i && byte_sel_i;
    end
  end

  assign rword_o       = {rhi_q, rlo_q};
  assign rword_valid_o = rvalid_q;

endmodule

`default_nettype wire

// ==== hyper_ca_shifter.sv ====
`default_nettype none

module hyper_ca_shifter #(
  parameter int ADDR_WIDTH = 22
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             load_i,
  input  logic                             write_i,
  input  logic                             reg_i,
  input  logic [ADDR_WIDTH-1:0]            addr_i,
  input  logic                             shift_i,
  output logic [hyper_pkg::DQ_WIDTH-1:0]   byte_o
);

  logic [hyper_pkg::CA_WIDTH-1:0] ca_q;
  logic [hyper_pkg::CA_WIDTH-1:0] ca_d;

  // pack the request into the CA layout
  always_comb begin
    ca_d = '0;
    ca_d[hyper_pkg::CA_RW_BIT]    = !write_i;
    ca_d[hyper_pkg::CA_AS_BIT]    = reg_i;
    ca_d[hyper_pkg::CA_BURST_BIT] = 1'b1;
    // upper word address bits
    ca_d[hyper_pkg::CA_ROW_LSB +: ADDR_WIDTH - hyper_pkg::CA_COL_BITS] =
      addr_i[ADDR_WIDTH-1:hyper_pkg::CA_COL_BITS];
    // lowest word address bits
    ca_d[hyper_pkg::CA_COL_BITS-1:0] = addr_i[hyper_pkg::CA_COL_BITS-1:0];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ca_q <= '0;
    end else if (load_i) begin
      ca_q <= ca_d;
    end else if (shift_i) begin
      // next byte moves to the top
      ca_q <= ca_q << hyper_pkg::DQ_WIDTH;
    end
  end

  // msb byte goes out first
  assign byte_o = ca_q[hyper_pkg::CA_WIDTH-1 -: hyper_pkg::DQ_WIDTH];

endmodule

`default_nettype wire

// ==== hyper_cycle_counter.sv ====
`default_nettype none

module hyper_cycle_counter (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       load_i,
  input  logic [7:0] load_value_i,
  input  logic       enable_i,
  output logic       done_o,
  output logic       odd_o
);

  logic [7:0] count_q;

  // last step of the phase, count goes to zero this cycle
  assign done_o = enable_i && (count_q == 8'd1);

  // data phases load an even count
  // so an even count means the high byte is on the bus
  assign odd_o = count_q[0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (load_i) begin
      // reload wins over a step in the same cycle
      count_q <= load_value_i;
    end else if (enable_i && (count_q != '0)) begin
      count_q <= count_q - 8'd1;
    end
  end

endmodule

`default_nettype wire

// ==== hyper_fifo.sv ====
`default_nettype none

module hyper_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [15:0]
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       push_i,
  input  payload_t                   data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output payload_t                   data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH+1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // pointer wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign free_o  = CNT_W'(DEPTH) - count_q;

  // head entry straight from storage
  assign data_o = mem_q[rd_ptr_q];

  // overflow and underflow requests are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // occupancy only moves when one side acts alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hyper_pkg.sv ====
`default_nettype none

package hyper_pkg;

  // command/address word, sent as six bytes msb first
  localparam int CA_WIDTH = 48;

  // read/write flag, high for a read
  localparam int CA_RW_BIT = 47;

  // address space, high selects the register space
  localparam int CA_AS_BIT = 46;

  // burst type, high for linear (always set here)
  localparam int CA_BURST_BIT = 45;

  // upper address field starts here and holds word address bits 3 and up
  localparam int CA_ROW_LSB = 16;

  // low address bits sit at the bottom of the word
  // bits 15 to 3 are reserved and zero
  localparam int CA_COL_BITS = 3;

  // pin and client data widths
  localparam int DQ_WIDTH = 8;
  localparam int WORD_WIDTH = 16;

  // bytes in the CA phase
  localparam int CA_BYTES = CA_WIDTH / DQ_WIDTH;

  // configuration register after power-up
  localparam logic [WORD_WIDTH-1:0] CFG_REG_RESET = 16'h8f1f;

endpackage

`default_nettype wire
